/* ram_access_pkg.sv */
// shared widths, APB register map and packed structs
// for the 256x11 two-port RAM access wrapper
`default_nettype none

package ram_access_pkg;

  // ---------------------------------------------------------------------------
  // array geometry
  // ---------------------------------------------------------------------------
  localparam int RAM_ADDR_W = 8;
  localparam int RAM_DATA_W = 11;
  localparam int RAM_DEPTH  = 256;
  // self-test pattern, replicated across the word
  localparam int MBIST_DI_W = 2;

  // ---------------------------------------------------------------------------
  // APB register map
  // ---------------------------------------------------------------------------
  localparam int APB_ADDR_W = 5;
  localparam int APB_DATA_W = 32;

  localparam logic [APB_ADDR_W-1:0] REG_WADDR = 5'h00;
  localparam logic [APB_ADDR_W-1:0] REG_RADDR = 5'h04;
  localparam logic [APB_ADDR_W-1:0] REG_WDATA = 5'h08;
  // bit 0 starts a write, bit 1 starts a read
  localparam logic [APB_ADDR_W-1:0] REG_CTRL  = 5'h0c;
  // read-only view of the capture register
  localparam logic [APB_ADDR_W-1:0] REG_DOUT  = 5'h10;

  // synchronized access modes
  typedef struct packed {
    logic debug;
    logic mbist;
  } ram_mode_t;

  // one access to the array, write and read side
  typedef struct packed {
    logic                  we;
    logic [RAM_ADDR_W-1:0] waddr;
    logic [RAM_DATA_W-1:0] wdata;
    logic                  re;
    logic [RAM_ADDR_W-1:0] raddr;
  } ram_req_t;

  // debug request from the APB block
  typedef struct packed {
    logic                  wr_go;
    logic                  rd_go;
    logic [RAM_ADDR_W-1:0] waddr;
    logic [RAM_ADDR_W-1:0] raddr;
    logic [RAM_DATA_W-1:0] wdata;
  } dbg_cmd_t;

endpackage

`default_nettype wire

/* ram_mode_sync.sv */
// synchronizer chain for debug_mode and mbist_en
// produces the mode struct with debug taking priority
`timescale 1ns/1ns
`default_nettype none

module ram_mode_sync import ram_access_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  wire       clk,
  input  wire       mbist_ramaccess_rst_,
  input  wire       debug_mode,
  input  wire       mbist_en,
  output ram_mode_t mode
);

  // bit 1 carries debug_mode, bit 0 carries mbist_en
  logic [1:0] sync_q [SYNC_STAGES];
  logic [1:0] sync_out;

  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= {debug_mode, mbist_en};
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign sync_out = sync_q[SYNC_STAGES-1];

  // self-test is masked while debug owns the array
  assign mode.debug = sync_out[1];
  assign mode.mbist = sync_out[0] & ~sync_out[1];

endmodule

`default_nettype wire

/* ram_debug_apb.sv */
// APB slave for debug access to the RAM
// address, write data and control registers, capture readback
`timescale 1ns/1ns
`default_nettype none

module ram_debug_apb import ram_access_pkg::*; (
  input  wire                        clk,
  input  wire                        mbist_ramaccess_rst_,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire       [APB_ADDR_W-1:0] paddr,
  input  wire       [APB_DATA_W-1:0] pwdata,
  output logic      [APB_DATA_W-1:0] prdata,
  output logic                       pready,
  input  wire       [RAM_DATA_W-1:0] capture_q,
  output dbg_cmd_t                   cmd
);

  logic                  apb_wr;
  logic [RAM_ADDR_W-1:0] waddr_q;
  logic [RAM_ADDR_W-1:0] raddr_q;
  logic [RAM_DATA_W-1:0] wdata_q;
  logic                  wr_go_q;
  logic                  rd_go_q;

  // ---------------------------------------------------------------------------
  // register writes, taken at the access-cycle edge
  // ---------------------------------------------------------------------------
  assign apb_wr = psel & penable & pwrite;

  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      waddr_q <= '0;
      raddr_q <= '0;
      wdata_q <= '0;
    end else if (apb_wr) begin
      if (paddr == REG_WADDR) begin
        waddr_q <= pwdata[RAM_ADDR_W-1:0];
      end
      if (paddr == REG_RADDR) begin
        raddr_q <= pwdata[RAM_ADDR_W-1:0];
      end
      if (paddr == REG_WDATA) begin
        wdata_q <= pwdata[RAM_DATA_W-1:0];
      end
    end
  end

  // go pulses last exactly one cycle after the CTRL write
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      wr_go_q <= 1'b0;
      rd_go_q <= 1'b0;
    end else begin
      wr_go_q <= apb_wr & (paddr == REG_CTRL) & pwdata[0];
      rd_go_q <= apb_wr & (paddr == REG_CTRL) & pwdata[1];
    end
  end

  // ---------------------------------------------------------------------------
  // readback, CTRL reads as zero
  // ---------------------------------------------------------------------------
  always_comb begin
    prdata = '0;
    case (paddr)
      REG_WADDR: prdata[RAM_ADDR_W-1:0] = waddr_q;
      REG_RADDR: prdata[RAM_ADDR_W-1:0] = raddr_q;
      REG_WDATA: prdata[RAM_DATA_W-1:0] = wdata_q;
      REG_DOUT:  prdata[RAM_DATA_W-1:0] = capture_q;
      default:   prdata = '0;
    endcase
  end

  // no wait states
  assign pready = 1'b1;

  assign cmd.wr_go = wr_go_q;
  assign cmd.rd_go = rd_go_q;
  assign cmd.waddr = waddr_q;
  assign cmd.raddr = raddr_q;
  assign cmd.wdata = wdata_q;

endmodule

`default_nettype wire

/* ram_port_decode.sv */
// request mux over debug, self-test and functional ports
// plus capture enable generation
`timescale 1ns/1ns
`default_nettype none

module ram_port_decode import ram_access_pkg::*; (
  input  wire                        clk,
  input  wire                        mbist_ramaccess_rst_,
  input  ram_mode_t                  mode,
  input  dbg_cmd_t                   cmd,
  input  wire                        we,
  input  wire       [RAM_ADDR_W-1:0] wa,
  input  wire       [RAM_DATA_W-1:0] di,
  input  wire                        re,
  input  wire       [RAM_ADDR_W-1:0] ra,
  input  wire                        ore,
  input  wire                        write_inh,
  input  wire                        mbist_we,
  input  wire       [RAM_ADDR_W-1:0] mbist_wa,
  input  wire       [MBIST_DI_W-1:0] mbist_di,
  input  wire                        mbist_ce,
  input  wire       [RAM_ADDR_W-1:0] mbist_ra,
  output ram_req_t                   req,
  output logic                       capture_en
);

  logic [RAM_DATA_W-1:0] mbist_word;
  logic                  test_rd;
  logic                  test_rd_q;

  // pattern bit 0 on top, then five copies of the pattern
  assign mbist_word = {mbist_di[0], {5{mbist_di}}};

  // ---------------------------------------------------------------------------
  // source select, debug over self-test over functional
  // ---------------------------------------------------------------------------
  always_comb begin
    if (mode.debug) begin
      req.we    = cmd.wr_go;
      req.waddr = cmd.waddr;
      req.wdata = cmd.wdata;
      req.re    = cmd.rd_go;
      req.raddr = cmd.raddr;
    end else if (mode.mbist) begin
      req.we    = mbist_we;
      req.waddr = mbist_wa;
      req.wdata = mbist_word;
      req.re    = mbist_ce;
      req.raddr = mbist_ra;
    end else begin
      req.we    = we;
      req.waddr = wa;
      req.wdata = di;
      req.re    = re;
      req.raddr = ra;
    end
    // write inhibit holds off every source
    req.we = req.we & ~write_inh;
  end

  // ---------------------------------------------------------------------------
  // capture enable
  // ---------------------------------------------------------------------------
  // test reads capture one cycle after the array read
  assign test_rd = (mode.debug & cmd.rd_go) | (mode.mbist & mbist_ce);

  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      test_rd_q <= 1'b0;
    end else begin
      test_rd_q <= test_rd;
    end
  end

  assign capture_en = (mode.debug | mode.mbist) ? test_rd_q : ore;

endmodule

`default_nettype wire

/* ram_array.sv */
// 256x11 storage, synchronous write port and registered read port
`timescale 1ns/1ns
`default_nettype none

module ram_array import ram_access_pkg::*; (
  input  wire                   clk,
  input  ram_req_t              req,
  output logic [RAM_DATA_W-1:0] rdata
);

  logic [RAM_DATA_W-1:0] mem [RAM_DEPTH];

  // ---------------------------------------------------------------------------
  // write port
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (req.we) begin
      mem[req.waddr] <= req.wdata;
    end
  end

  // ---------------------------------------------------------------------------
  // read port
  // ---------------------------------------------------------------------------
  // output holds the last word read until the next re
  always_ff @(posedge clk) begin
    if (req.re) begin
      rdata <= mem[req.raddr];
    end
  end

endmodule

`default_nettype wire

/* ram_capture.sv */
// output data register with read bypass select
`timescale 1ns/1ns
`default_nettype none

module ram_capture import ram_access_pkg::*; (
  input  wire                   clk,
  input  wire                   mbist_ramaccess_rst_,
  input  wire                   capture_en,
  input  wire                   read_inh,
  input  wire  [RAM_DATA_W-1:0] rdata,
  input  wire  [RAM_DATA_W-1:0] wdata,
  output logic [RAM_DATA_W-1:0] capture_q
);

  logic [RAM_DATA_W-1:0] capture_d;

  // bypass takes the selected write data in place of the array
  assign capture_d = read_inh ? wdata : rdata;

  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      capture_q <= '0;
    end else if (capture_en) begin
      capture_q <= capture_d;
    end
  end

endmodule

`default_nettype wire

/* ram_access_top.sv */
// top level of the RAM access wrapper
// mode sync, APB debug block, port decode, array and capture register
`timescale 1ns/1ns
`default_nettype none

module ram_access_top import ram_access_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  wire                   clk,
  input  wire                   mbist_ramaccess_rst_,
  // functional port
  input  wire                   we,
  input  wire  [RAM_ADDR_W-1:0] wa,
  input  wire  [RAM_DATA_W-1:0] di,
  input  wire                   re,
  input  wire  [RAM_ADDR_W-1:0] ra,
  input  wire                   ore,
  input  wire                   write_inh,
  input  wire                   read_inh,
  // self-test port
  input  wire                   mbist_en,
  input  wire                   mbist_we,
  input  wire  [RAM_ADDR_W-1:0] mbist_wa,
  input  wire  [MBIST_DI_W-1:0] mbist_di,
  input  wire                   mbist_ce,
  input  wire  [RAM_ADDR_W-1:0] mbist_ra,
  // debug port
  input  wire                   debug_mode,
  input  wire                   psel,
  input  wire                   penable,
  input  wire                   pwrite,
  input  wire  [APB_ADDR_W-1:0] paddr,
  input  wire  [APB_DATA_W-1:0] pwdata,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  // outputs
  output logic [RAM_DATA_W-1:0] dout,
  output logic [RAM_DATA_W-1:0] mbist_do
);

  ram_mode_t             mode;
  dbg_cmd_t              cmd;
  ram_req_t              req;
  logic                  capture_en;
  logic [RAM_DATA_W-1:0] rdata;
  logic [RAM_DATA_W-1:0] capture_q;

  ram_mode_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) ram_mode_sync_inst (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .debug_mode           (debug_mode),
    .mbist_en             (mbist_en),
    .mode                 (mode)
  );

  ram_debug_apb ram_debug_apb_inst (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .psel                 (psel),
    .penable              (penable),
    .pwrite               (pwrite),
    .paddr                (paddr),
    .pwdata               (pwdata),
    .prdata               (prdata),
    .pready               (pready),
    .capture_q            (capture_q),
    .cmd                  (cmd)
  );

  ram_port_decode ram_port_decode_inst (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .mode                 (mode),
    .cmd                  (cmd),
    .we                   (we),
    .wa                   (wa),
    .di                   (di),
    .re                   (re),
    .ra                   (ra),
    .ore                  (ore),
    .write_inh            (write_inh),
    .mbist_we             (mbist_we),
    .mbist_wa             (mbist_wa),
    .mbist_di             (mbist_di),
    .mbist_ce             (mbist_ce),
    .mbist_ra             (mbist_ra),
    .req                  (req),
    .capture_en           (capture_en)
  );

  ram_array ram_array_inst (
    .clk   (clk),
    .req   (req),
    .rdata (rdata)
  );

  // bypass data is the write data chosen by the port decode
  ram_capture ram_capture_inst (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .capture_en           (capture_en),
    .read_inh             (read_inh),
    .rdata                (rdata),
    .wdata                (req.wdata),
    .capture_q            (capture_q)
  );

  assign dout     = capture_q;
  assign mbist_do = capture_q;

endmodule

`default_nettype wire

/* tb_ram_access_tasks.svh */
// reference memory model and stimulus tasks
// for the functional, self-test and APB debug ports
`ifndef TB_RAM_ACCESS_TASKS_SVH
`define TB_RAM_ACCESS_TASKS_SVH

logic [RAM_DATA_W-1:0] model [RAM_DEPTH];
logic [RAM_ADDR_W-1:0] rd_addrs [$];

task automatic check_value(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
  assert (act === exp) else begin
    $display("** Error at %0t ns: %s expected 'h%0h, got 'h%0h", $time, name, exp, act);
    error_count++;
  end
endtask

task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk);
endtask

// drive the mode inputs and wait out the synchronizer
task automatic set_modes(input logic dbg, input logic mb);
  @(posedge clk);
  debug_mode <= dbg;
  mbist_en   <= mb;
  wait_cycles(SYNC_STAGES + 1);
endtask

// ---------------------------------------------------------------------------
// functional port
// ---------------------------------------------------------------------------
task automatic func_write(input logic [RAM_ADDR_W-1:0] a, input logic [RAM_DATA_W-1:0] d,
                          input logic inh);
  @(posedge clk);
  we        <= 1'b1;
  wa        <= a;
  di        <= d;
  write_inh <= inh;
  @(posedge clk);
  we        <= 1'b0;
  write_inh <= 1'b0;
endtask

// re on consecutive cycles with ore one cycle behind
// dout holds each word two cycles after its re
task automatic func_read_burst();
  int n;
  n = rd_addrs.size();
  for (int i = 0; i < n + 2; i++) begin
    @(posedge clk);
    re  <= (i < n);
    ore <= (i >= 1) && (i <= n);
    if (i < n) begin
      ra <= rd_addrs[i];
    end
    if (i >= 2) begin
      @(negedge clk);
      check_value("dout", 32'(model[rd_addrs[i-2]]), 32'(dout));
    end
  end
  rd_addrs.delete();
endtask

// ---------------------------------------------------------------------------
// self-test port
// ---------------------------------------------------------------------------
task automatic mbist_write(input logic [RAM_ADDR_W-1:0] a, input logic [MBIST_DI_W-1:0] p);
  logic [RAM_DATA_W-1:0] w;
  @(posedge clk);
  mbist_we <= 1'b1;
  mbist_wa <= a;
  mbist_di <= p;
  @(posedge clk);
  mbist_we <= 1'b0;
  // even word bits carry pattern bit 0, odd bits pattern bit 1
  for (int b = 0; b < RAM_DATA_W; b++) begin
    w[b] = p[b % MBIST_DI_W];
  end
  model[a] = w;
endtask

task automatic mbist_read_check(input logic [RAM_ADDR_W-1:0] a);
  @(posedge clk);
  mbist_ce <= 1'b1;
  mbist_ra <= a;
  @(posedge clk);
  mbist_ce <= 1'b0;
  @(posedge clk);
  @(negedge clk);
  check_value("mbist_do", 32'(model[a]), 32'(mbist_do));
endtask

// ---------------------------------------------------------------------------
// APB debug port
// ---------------------------------------------------------------------------
task automatic apb_write(input logic [APB_ADDR_W-1:0] a, input logic [31:0] d);
  @(posedge clk);
  psel    <= 1'b1;
  penable <= 1'b0;
  pwrite  <= 1'b1;
  paddr   <= a;
  pwdata  <= d;
  @(posedge clk);
  penable <= 1'b1;
  @(posedge clk);
  psel    <= 1'b0;
  penable <= 1'b0;
  pwrite  <= 1'b0;
endtask

task automatic apb_read(input logic [APB_ADDR_W-1:0] a, output logic [31:0] d);
  @(posedge clk);
  psel    <= 1'b1;
  penable <= 1'b0;
  pwrite  <= 1'b0;
  paddr   <= a;
  @(posedge clk);
  penable <= 1'b1;
  // prdata is stable in the access phase
  @(negedge clk);
  check_value("pready", 32'd1, 32'(pready));
  d = prdata;
  @(posedge clk);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task automatic debug_write(input logic [RAM_ADDR_W-1:0] a, input logic [RAM_DATA_W-1:0] d);
  apb_write(REG_WADDR, 32'(a));
  apb_write(REG_WDATA, 32'(d));
  apb_write(REG_CTRL, 32'h1);
  model[a] = d;
endtask

task automatic debug_read_check(input logic [RAM_ADDR_W-1:0] a);
  logic [31:0] rd;
  apb_write(REG_RADDR, 32'(a));
  apb_write(REG_CTRL, 32'h2);
  wait_cycles(3);
  apb_read(REG_DOUT, rd);
  check_value("prdata", 32'(model[a]), rd);
endtask

`endif

/* tb_ram_access.sv */
// testbench for the RAM access wrapper
// clock, reset, DUT, watchdog, test sequence and summary
`timescale 1ns/1ns
`default_nettype none

module tb_ram_access import ram_access_pkg::*; ();

  localparam int SYNC_STAGES = 2;
  localparam int CLK_PERIOD  = 10;
  // cycle budget per test
  localparam int RESET_CYCLES    = 20;
  localparam int FUNC_CYCLES     = 60;
  localparam int INH_CYCLES      = 20;
  localparam int MBIST_CYCLES    = 50;
  localparam int DEBUG_CYCLES    = 70;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + FUNC_CYCLES + INH_CYCLES + MBIST_CYCLES
                                   + DEBUG_CYCLES + 100;

  logic                  clk;
  logic                  mbist_ramaccess_rst_;
  logic                  we;
  logic                  re;
  logic                  ore;
  logic                  write_inh;
  logic                  read_inh;
  logic [RAM_ADDR_W-1:0] wa;
  logic [RAM_ADDR_W-1:0] ra;
  logic [RAM_DATA_W-1:0] di;
  logic                  mbist_en;
  logic                  mbist_we;
  logic                  mbist_ce;
  logic [RAM_ADDR_W-1:0] mbist_wa;
  logic [RAM_ADDR_W-1:0] mbist_ra;
  logic [MBIST_DI_W-1:0] mbist_di;
  logic                  debug_mode;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata;
  wire  [APB_DATA_W-1:0] prdata;
  wire                   pready;
  wire  [RAM_DATA_W-1:0] dout;
  wire  [RAM_DATA_W-1:0] mbist_do;

  int                    seed;
  int                    error_count;
  int                    test_start_errors;
  int                    pass_count;
  int                    fail_count;
  logic [RAM_ADDR_W-1:0] written [$];

  `include "tb_ram_access_tasks.svh"

  ram_access_top #(
    .SYNC_STAGES (SYNC_STAGES)
  ) ram_access_top_inst (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .we                   (we),
    .wa                   (wa),
    .di                   (di),
    .re                   (re),
    .ra                   (ra),
    .ore                  (ore),
    .write_inh            (write_inh),
    .read_inh             (read_inh),
    .mbist_en             (mbist_en),
    .mbist_we             (mbist_we),
    .mbist_wa             (mbist_wa),
    .mbist_di             (mbist_di),
    .mbist_ce             (mbist_ce),
    .mbist_ra             (mbist_ra),
    .debug_mode           (debug_mode),
    .psel                 (psel),
    .penable              (penable),
    .pwrite               (pwrite),
    .paddr                (paddr),
    .pwdata               (pwdata),
    .prdata               (prdata),
    .pready               (pready),
    .dout                 (dout),
    .mbist_do             (mbist_do)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic finish_test(input string name);
    if (error_count == test_start_errors) begin
      pass_count++;
      $display("test %s: passed", name);
    end else begin
      fail_count++;
      $display("test %s: failed, %0d errors", name, error_count - test_start_errors);
    end
    test_start_errors = error_count;
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0]           rnd;
    logic [31:0]           rd;
    logic [RAM_ADDR_W-1:0] addr;
    logic [RAM_DATA_W-1:0] data;
    logic [MBIST_DI_W-1:0] pat;
    seed = 32'h24f6;
    error_count = 0;
    test_start_errors = 0;
    pass_count = 0;
    fail_count = 0;
    mbist_ramaccess_rst_ <= 1'b0;
    we         <= 1'b0;
    re         <= 1'b0;
    ore        <= 1'b0;
    write_inh  <= 1'b0;
    read_inh   <= 1'b0;
    wa         <= '0;
    ra         <= '0;
    di         <= '0;
    mbist_en   <= 1'b0;
    mbist_we   <= 1'b0;
    mbist_ce   <= 1'b0;
    mbist_wa   <= '0;
    mbist_ra   <= '0;
    mbist_di   <= '0;
    debug_mode <= 1'b0;
    psel       <= 1'b0;
    penable    <= 1'b0;
    pwrite     <= 1'b0;
    paddr      <= '0;
    pwdata     <= '0;
    wait_cycles(5);
    mbist_ramaccess_rst_ <= 1'b1;

    @(negedge clk);
    check_value("dout", 32'd0, 32'(dout));
    apb_read(REG_DOUT, rd);
    check_value("prdata", 32'd0, rd);
    finish_test("reset");

    for (int i = 0; i < 8; i++) begin
      rnd  = $random(seed);
      addr = rnd[RAM_ADDR_W-1:0];
      data = rnd[RAM_ADDR_W +: RAM_DATA_W];
      func_write(addr, data, 1'b0);
      model[addr] = data;
      written.push_back(addr);
    end
    foreach (written[i]) begin
      rd_addrs.push_back(written[i]);
      func_read_burst();
    end
    rd_addrs = written;
    func_read_burst();
    finish_test("functional write and read");

    // inhibited write must leave the old word
    func_write(written[0], ~model[written[0]], 1'b1);
    rd_addrs.push_back(written[0]);
    func_read_burst();
    // bypass during the capture cycle returns di
    data = ~model[written[1]];
    @(posedge clk);
    re <= 1'b1;
    ra <= written[1];
    @(posedge clk);
    re       <= 1'b0;
    ore      <= 1'b1;
    read_inh <= 1'b1;
    di       <= data;
    @(posedge clk);
    ore      <= 1'b0;
    read_inh <= 1'b0;
    @(negedge clk);
    check_value("dout", 32'(data), 32'(dout));
    finish_test("inhibits");

    set_modes(1'b0, 1'b1);
    for (int p = 0; p < 4; p++) begin
      pat = p[MBIST_DI_W-1:0];
      mbist_write(written[p], pat);
      mbist_read_check(written[p]);
    end
    // functional write is ignored while self-test owns the array
    func_write(written[4], ~model[written[4]], 1'b0);
    mbist_read_check(written[4]);
    set_modes(1'b0, 1'b0);
    finish_test("self-test");

    set_modes(1'b1, 1'b0);
    rnd = $random(seed);
    debug_write(written[5], rnd[RAM_DATA_W-1:0]);
    debug_read_check(written[5]);
    // self-test requests stay active while debug is also set
    set_modes(1'b1, 1'b1);
    @(posedge clk);
    mbist_we <= 1'b1;
    mbist_wa <= written[6];
    mbist_di <= 2'b01;
    mbist_ce <= 1'b1;
    mbist_ra <= written[6];
    rnd = $random(seed);
    debug_write(written[6], rnd[RAM_DATA_W-1:0]);
    debug_read_check(written[6]);
    @(posedge clk);
    mbist_we <= 1'b0;
    mbist_ce <= 1'b0;
    set_modes(1'b0, 1'b0);
    finish_test("debug");

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             pass_count, fail_count, error_count);
    if (fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
ram_access_pkg.sv
ram_mode_sync.sv
ram_debug_apb.sv
ram_port_decode.sv
ram_array.sv
ram_capture.sv
ram_access_top.sv
tb_ram_access.sv

/* run.sh */
#!/bin/sh
# compile and run the RAM access testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_ram_access \
  -Mdir obj_dir -o sim_ram_access
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_ram_access > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
